// ==== dv/hybrid_predictor_patterns.txt ====
# fetch_instr fetch_pc res_instr res_pc res_taken res_target res_pred flush exp_taken exp_target exp_pred
# Words in hex, single bits and the 2-bit prediction fields in binary
# Cold beq and bne miss in the BTB
10220003 00001000 00000000 00000000 0 00000000 00 0 0 00000000 00
14220002 00001004 00000000 00000000 0 00000000 00 0 0 00000000 00
# j fills the BTB, alias at the same index misses, flush empties it
00000000 00000000 08000c00 00002010 1 00003000 00 0 0 00000000 00
08000c00 00002010 00000000 00000000 0 00000000 00 0 1 00003000 00
08000c00 00002410 00000000 00000000 0 00000000 00 0 0 00000000 00
08000c00 00002010 00000000 00000000 0 00000000 00 1 0 00000000 00
08000c00 00002010 00000000 00000000 0 00000000 00 0 0 00000000 00
# beq at 4020 fetched and resolved taken every cycle
10220003 00004020 10220003 00004020 1 00004100 00 0 0 00000000 00
10220003 00004020 10220003 00004020 1 00004100 00 0 0 00004100 00
10220003 00004020 10220003 00004020 1 00004100 00 0 0 00004100 00
10220003 00004020 10220003 00004020 1 00004100 00 0 0 00004100 00
10220003 00004020 10220003 00004020 1 00004100 00 0 0 00004100 00
10220003 00004020 10220003 00004020 1 00004100 00 0 1 00004100 01
10220003 00004020 10220003 00004020 1 00004100 00 0 1 00004100 01
10220003 00004020 10220003 00004020 1 00004100 00 0 1 00004100 11
10220003 00004020 00000000 00000000 0 00000000 00 0 1 00004100 11
# Chooser at 5030, local wins first, global after two updates
00000000 00000000 10220003 00005030 1 00005100 00 0 0 00000000 00
00000000 00000000 10220003 00004020 0 00004100 00 0 0 00000000 00
10220003 00005030 00000000 00000000 0 00000000 00 0 1 00005100 01
00000000 00000000 10220003 00005030 1 00005100 10 0 0 00000000 00
00000000 00000000 10220003 00005030 1 00005100 10 0 0 00000000 00
00000000 00000000 10220003 00004020 0 00004100 00 0 0 00000000 00
10220003 00005030 00000000 00000000 0 00000000 00 0 0 00005100 01
# Return stack, one call then pop
00000000 00000000 0c001c00 00006000 1 00007000 00 0 0 00000000 00
03e00008 00007010 00000000 00000000 0 00000000 00 0 1 00006004 00
03e00008 00007010 03e00008 00007010 1 00006004 00 0 1 00006004 00
03e00008 00007010 00000000 00000000 0 00000000 00 0 0 00000000 00
# Five calls overflow the stack, then four returns
00000000 00000000 0c001c00 00008000 1 00009000 00 0 0 00000000 00
00000000 00000000 0c001c00 00008100 1 00009000 00 0 0 00000000 00
00000000 00000000 0c001c00 00008200 1 00009000 00 0 0 00000000 00
00000000 00000000 0c001c00 00008300 1 00009000 00 0 0 00000000 00
00000000 00000000 0c001c00 00008400 1 00009000 00 0 0 00000000 00
03e00008 00007010 03e00008 00007010 1 00008404 00 0 1 00008404 00
03e00008 00007010 03e00008 00007010 1 00008304 00 0 1 00008304 00
03e00008 00007010 03e00008 00007010 1 00008204 00 0 1 00008204 00
03e00008 00007010 03e00008 00007010 1 00008104 00 0 1 00008104 00
03e00008 00007010 00000000 00000000 0 00000000 00 0 0 00000000 00

// ==== hybrid_predictor.f ====
+incdir+verilog
verilog/bp_pkg.sv
verilog/branch_decoder.sv
verilog/branch_target_buffer.sv
verilog/global_predictor.sv
verilog/local_predictor.sv
verilog/meta_predictor.sv
verilog/return_address_stack.sv
verilog/hybrid_predictor.sv
dv/hybrid_predictor_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
    -f hybrid_predictor.f --top-module hybrid_predictor_tb \
    -Mdir obj_dir -o hybrid_predictor_sim || exit 1

./obj_dir/hybrid_predictor_sim > sim.log 2>&1 || { cat sim.log; exit 1; }

cat sim.log && ! grep -q "Done: errors found" sim.log

// ==== dv/hybrid_predictor_tb.sv ====
`default_nettype none

module hybrid_predictor_tb
    import bp_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_PATTERNS = 128;
    localparam string PATTERN_FILE = "dv/hybrid_predictor_patterns.txt";

    logic       CLK;
    logic       RESET;
    logic       flush;
    addr_t      fetch_pc;
    instr_t     fetch_instr;
    addr_t      resolved_pc;
    instr_t     resolved_instr;
    logic       resolved_taken;
    addr_t      resolved_target;
    logic [1:0] resolved_predictions;
    logic       taken;
    addr_t      target;
    logic [1:0] predictions_out;

    // One entry per data line of the pattern file
    instr_t     pat_fetch_instr [MAX_PATTERNS];
    addr_t      pat_fetch_pc    [MAX_PATTERNS];
    instr_t     pat_res_instr   [MAX_PATTERNS];
    addr_t      pat_res_pc      [MAX_PATTERNS];
    logic       pat_res_taken   [MAX_PATTERNS];
    addr_t      pat_res_target  [MAX_PATTERNS];
    logic [1:0] pat_res_pred    [MAX_PATTERNS];
    logic       pat_flush       [MAX_PATTERNS];
    logic       exp_taken       [MAX_PATTERNS];
    addr_t      exp_target      [MAX_PATTERNS];
    logic [1:0] exp_pred        [MAX_PATTERNS];

    int   num_patterns;
    int   check_count;
    int   error_count;
    int   cur_pattern;
    logic loaded;

    hybrid_predictor i_dut (
        .CLK(CLK),
        .RESET(RESET),
        .flush(flush),
        .fetch_pc(fetch_pc),
        .fetch_instr(fetch_instr),
        .resolved_pc(resolved_pc),
        .resolved_instr(resolved_instr),
        .resolved_taken(resolved_taken),
        .resolved_target(resolved_target),
        .resolved_predictions(resolved_predictions),
        .taken(taken),
        .target(target),
        .predictions_out(predictions_out)
    );

    initial CLK = 1'b0;
    always #50 CLK = ~CLK;

    task automatic load_patterns();
        int         fd;
        int         fields;
        string      line;
        instr_t     f_instr;
        instr_t     r_instr;
        addr_t      f_pc;
        addr_t      r_pc;
        addr_t      r_tgt;
        addr_t      e_tgt;
        logic       r_tk;
        logic       fl;
        logic       e_tk;
        logic [1:0] r_pr;
        logic [1:0] e_pr;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the pattern file %s", PATTERN_FILE);
            error_count++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Skip blank lines and column notes
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%h %h %h %h %b %h %b %b %b %h %b", f_instr, f_pc,
                             r_instr, r_pc, r_tk, r_tgt, r_pr, fl, e_tk, e_tgt, e_pr);
            if (fields != 11 || num_patterns >= MAX_PATTERNS) begin
                $display("Pattern line could not be read: %s", line);
                error_count++;
                continue;
            end
            pat_fetch_instr[num_patterns] = f_instr;
            pat_fetch_pc[num_patterns]    = f_pc;
            pat_res_instr[num_patterns]   = r_instr;
            pat_res_pc[num_patterns]      = r_pc;
            pat_res_taken[num_patterns]   = r_tk;
            pat_res_target[num_patterns]  = r_tgt;
            pat_res_pred[num_patterns]    = r_pr;
            pat_flush[num_patterns]       = fl;
            exp_taken[num_patterns]       = e_tk;
            exp_target[num_patterns]      = e_tgt;
            exp_pred[num_patterns]        = e_pr;
            num_patterns++;
        end
        $fclose(fd);
        if (num_patterns == 0) begin
            $display("The pattern file holds no patterns");
            error_count++;
        end
    endtask

    task automatic apply_pattern(input int idx);
        fetch_instr          <= pat_fetch_instr[idx];
        fetch_pc             <= pat_fetch_pc[idx];
        resolved_instr       <= pat_res_instr[idx];
        resolved_pc          <= pat_res_pc[idx];
        resolved_taken       <= pat_res_taken[idx];
        resolved_target      <= pat_res_target[idx];
        resolved_predictions <= pat_res_pred[idx];
        flush                <= pat_flush[idx];
    endtask

    task automatic apply_idle();
        fetch_instr          <= '0;
        fetch_pc             <= '0;
        resolved_instr       <= '0;
        resolved_pc          <= '0;
        resolved_taken       <= 1'b0;
        resolved_target      <= '0;
        resolved_predictions <= 2'b00;
        flush                <= 1'b0;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERR %0t %s expected %0h actual %0h (pattern %0d)",
                     $time, name, expected, actual, cur_pattern);
        end
    endtask

    initial begin
        RESET                = 1'b0;
        flush                = 1'b0;
        fetch_pc             = '0;
        fetch_instr          = '0;
        resolved_pc          = '0;
        resolved_instr       = '0;
        resolved_taken       = 1'b0;
        resolved_target      = '0;
        resolved_predictions = 2'b00;
        num_patterns         = 0;
        check_count          = 0;
        error_count          = 0;
        cur_pattern          = -1;
        loaded               = 1'b0;
        load_patterns();
        loaded = 1'b1;
        repeat (3) @(posedge CLK);
        // All outputs cleared by reset
        check_value("taken", 32'(1'b0), 32'(taken));
        check_value("target", 32'h0, target);
        check_value("predictions_out", 32'(2'b00), 32'(predictions_out));
        RESET <= 1'b1;
        // Prediction for pattern t shows after edge t+1 and is checked at edge t+2
        for (int t = 0; t < num_patterns + 2; t++) begin
            if (t > 0) begin
                @(posedge CLK);
            end
            if (t >= 2) begin
                cur_pattern = t - 2;
                check_value("taken", 32'(exp_taken[t-2]), 32'(taken));
                check_value("target", exp_target[t-2], target);
                check_value("predictions_out", 32'(exp_pred[t-2]), 32'(predictions_out));
            end
            if (t < num_patterns) begin
                apply_pattern(t);
            end else begin
                apply_idle();
            end
        end
        $display("Patterns: %0d, checks: %0d, errors: %0d", num_patterns, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Watchdog sized from the pattern count
    initial begin
        wait (loaded);
        #((num_patterns + 10) * 100);
        $display("Timeout: the run did not end within %0d clock cycles", num_patterns + 10);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/hybrid_predictor.sv ====
`default_nettype none

`include "bp_settings.svh"

module hybrid_predictor
    import bp_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       flush,
    input  addr_t      fetch_pc,
    input  instr_t     fetch_instr,
    input  addr_t      resolved_pc,
    input  instr_t     resolved_instr,
    input  logic       resolved_taken,
    input  addr_t      resolved_target,
    input  logic [1:0] resolved_predictions,
    output logic       taken,
    output addr_t      target,
    output logic [1:0] predictions_out
);

    logic f_cond, f_jump, f_ret;
    logic r_cond, r_jump, r_call, r_ret;
    logic res_any, res_cond;

    logic  btb_hit;
    addr_t btb_target;
    logic  g_taken, l_taken, use_global;
    logic  ras_valid, ras_push, ras_pop;
    addr_t ras_top;

    logic       dir_taken, ret_hit;
    logic       next_taken;
    addr_t      next_target;
    logic [1:0] next_pred;

    branch_decoder u_fetch_dec (
        .instr(fetch_instr), .is_cond(f_cond), .is_jump(f_jump),
        .is_call(), .is_return(f_ret)
    );

    branch_decoder u_res_dec (
        .instr(resolved_instr), .is_cond(r_cond), .is_jump(r_jump),
        .is_call(r_call), .is_return(r_ret)
    );

    // Update qualifiers from the resolve stage
    assign res_any  = r_cond | r_jump;
    assign res_cond = r_cond;
    assign ras_push = r_call;
    assign ras_pop  = r_ret & ras_valid;

    branch_target_buffer u_btb (
        .CLK(CLK), .RESET(RESET), .flush(flush),
        .lookup_pc(fetch_pc), .hit(btb_hit), .hit_target(btb_target),
        .write_en(res_any & resolved_taken), .write_pc(resolved_pc),
        .write_target(resolved_target)
    );

    global_predictor u_gshare (
        .CLK(CLK), .RESET(RESET), .lookup_pc(fetch_pc), .taken(g_taken),
        .update_en(res_cond), .update_pc(resolved_pc), .outcome(resolved_taken)
    );

    local_predictor u_local (
        .CLK(CLK), .RESET(RESET), .lookup_pc(fetch_pc), .taken(l_taken),
        .update_en(res_cond), .update_pc(resolved_pc), .outcome(resolved_taken)
    );

    meta_predictor u_meta (
        .CLK(CLK), .RESET(RESET), .lookup_pc(fetch_pc), .use_global(use_global),
        .update_en(res_cond), .update_pc(resolved_pc), .outcome(resolved_taken),
        .prior_global(resolved_predictions[1]), .prior_local(resolved_predictions[0])
    );

    return_address_stack u_ras (
        .CLK(CLK), .RESET(RESET), .push(ras_push),
        .push_addr(resolved_pc + 32'd4), .pop(ras_pop),
        .top_valid(ras_valid), .top_addr(ras_top)
    );

    // Returns bypass the BTB when the stack has an address
    assign ret_hit   = f_ret & ras_valid;
    assign dir_taken = use_global ? g_taken : l_taken;

    always_comb begin
        if (ret_hit) begin
            next_taken  = 1'b1;
            next_target = ras_top;
            next_pred   = 2'b00;
        end else begin
            next_taken  = btb_hit & (f_jump | (f_cond & dir_taken));
            next_target = btb_hit ? btb_target : '0;
            next_pred   = f_cond ? {g_taken, l_taken} : 2'b00;
        end
    end

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            taken           <= 1'b0;
            target          <= '0;
            predictions_out <= 2'b00;
        end else if (flush) begin
            taken           <= 1'b0;
            target          <= '0;
            predictions_out <= 2'b00;
        end else begin
            taken           <= next_taken;
            target          <= next_target;
            predictions_out <= next_pred;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/return_address_stack.sv ====
`default_nettype none

`include "bp_settings.svh"

module return_address_stack
    import bp_pkg::*;
(
    input  logic  CLK,
    input  logic  RESET,
    input  logic  push,
    input  addr_t push_addr,
    input  logic  pop,
    output logic  top_valid,
    output addr_t top_addr
);

    localparam int PTR_W = $clog2(`BP_RAS_DEPTH);
    localparam int CNT_W = $clog2(`BP_RAS_DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL = CNT_W'(`BP_RAS_DEPTH);

    addr_t            stack [`BP_RAS_DEPTH];
    logic [PTR_W-1:0] ptr;
    logic [PTR_W-1:0] ptr_up;
    logic [CNT_W-1:0] count;

    // ptr always points at the newest entry
    assign ptr_up    = ptr + 1'b1;
    assign top_valid = (count != '0);
    assign top_addr  = stack[ptr];

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            ptr   <= '0;
            count <= '0;
        end else if (push) begin
            // Wraps over the oldest entry once full
            ptr <= ptr_up;
            if (count != FULL) begin
                count <= count + 1'b1;
            end
        end else if (pop && top_valid) begin
            ptr   <= ptr - 1'b1;
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (push) begin
            stack[ptr_up] <= push_addr;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/meta_predictor.sv ====
`default_nettype none

`include "bp_settings.svh"

module meta_predictor
    import bp_pkg::*;
(
    input  logic  CLK,
    input  logic  RESET,
    input  addr_t lookup_pc,
    output logic  use_global,
    input  logic  update_en,
    input  addr_t update_pc,
    input  logic  outcome,
    input  logic  prior_global,
    input  logic  prior_local
);

    // Same size and PC slice as the gshare table
    localparam int ENTRIES = 2 ** `BP_GHR_BITS;

    ctr_t chooser [ENTRIES];

    logic [`BP_GHR_BITS-1:0] lk_idx;
    logic [`BP_GHR_BITS-1:0] upd_idx;
    logic                    disagree;

    assign lk_idx   = lookup_pc[`BP_GHR_BITS+1:2];
    assign upd_idx  = update_pc[`BP_GHR_BITS+1:2];
    assign disagree = prior_global ^ prior_local;

    assign use_global = chooser[lk_idx][1];

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < ENTRIES; i++) begin
                chooser[i] <= 2'd1;
            end
        end else if (update_en && disagree) begin
            // Count toward whichever side was right
            chooser[upd_idx] <= ctr_step(chooser[upd_idx], prior_global == outcome);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/local_predictor.sv ====
`default_nettype none

`include "bp_settings.svh"

module local_predictor
    import bp_pkg::*;
(
    input  logic  CLK,
    input  logic  RESET,
    input  addr_t lookup_pc,
    output logic  taken,
    input  logic  update_en,
    input  addr_t update_pc,
    input  logic  outcome
);

    // History table and pattern table are both 16 deep
    localparam int ENTRIES = 2 ** `BP_LHR_BITS;

    lhist_t lht [ENTRIES];
    ctr_t   pht [ENTRIES];

    logic [`BP_LHR_BITS-1:0] lk_idx;
    logic [`BP_LHR_BITS-1:0] upd_idx;
    lhist_t                  lk_hist;
    lhist_t                  upd_hist;

    assign lk_idx  = lookup_pc[`BP_LHR_BITS+1:2];
    assign upd_idx = update_pc[`BP_LHR_BITS+1:2];

    // First level picks the history, second level the counter
    assign lk_hist  = lht[lk_idx];
    assign upd_hist = lht[upd_idx];

    assign taken = pht[lk_hist][1];

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < ENTRIES; i++) begin
                lht[i] <= '0;
                pht[i] <= 2'd1;
            end
        end else if (update_en) begin
            pht[upd_hist] <= ctr_step(pht[upd_hist], outcome);
            lht[upd_idx]  <= {upd_hist[`BP_LHR_BITS-2:0], outcome};
        end
    end

endmodule

`default_nettype wire

// ==== verilog/global_predictor.sv ====
`default_nettype none

`include "bp_settings.svh"

module global_predictor
    import bp_pkg::*;
(
    input  logic  CLK,
    input  logic  RESET,
    input  addr_t lookup_pc,
    output logic  taken,
    input  logic  update_en,
    input  addr_t update_pc,
    input  logic  outcome
);

    localparam int ENTRIES = 2 ** `BP_GHR_BITS;

    ghist_t ghr;
    ctr_t   pht [ENTRIES];

    logic [`BP_GHR_BITS-1:0] lk_idx;
    logic [`BP_GHR_BITS-1:0] upd_idx;

    // gshare index, PC bits folded with global history
    assign lk_idx  = lookup_pc[`BP_GHR_BITS+1:2] ^ ghr;
    assign upd_idx = update_pc[`BP_GHR_BITS+1:2] ^ ghr;

    assign taken = pht[lk_idx][1];

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            ghr <= '0;
            for (int i = 0; i < ENTRIES; i++) begin
                pht[i] <= 2'd1;
            end
        end else if (update_en) begin
            pht[upd_idx] <= ctr_step(pht[upd_idx], outcome);
            // Newest outcome enters at bit 0
            ghr <= {ghr[`BP_GHR_BITS-2:0], outcome};
        end
    end

endmodule

`default_nettype wire

// ==== verilog/branch_target_buffer.sv ====
`default_nettype none

`include "bp_settings.svh"

module branch_target_buffer
    import bp_pkg::*;
(
    input  logic  CLK,
    input  logic  RESET,
    input  logic  flush,
    input  addr_t lookup_pc,
    output logic  hit,
    output addr_t hit_target,
    input  logic  write_en,
    input  addr_t write_pc,
    input  addr_t write_target
);

    localparam int IDX_W = $clog2(`BP_BTB_ENTRIES);
    localparam int TAG_W = $bits(addr_t) - IDX_W - 2;

    logic [`BP_BTB_ENTRIES-1:0] valid;
    logic [TAG_W-1:0]           tags    [`BP_BTB_ENTRIES];
    addr_t                      targets [`BP_BTB_ENTRIES];

    logic [IDX_W-1:0] lk_idx;
    logic [TAG_W-1:0] lk_tag;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;

    // Word-aligned PCs, so bits 1:0 are skipped
    assign lk_idx = lookup_pc[IDX_W+1:2];
    assign lk_tag = lookup_pc[$bits(addr_t)-1:IDX_W+2];
    assign wr_idx = write_pc[IDX_W+1:2];
    assign wr_tag = write_pc[$bits(addr_t)-1:IDX_W+2];

    assign hit        = valid[lk_idx] && (tags[lk_idx] == lk_tag);
    assign hit_target = targets[lk_idx];

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            valid <= '0;
        end else if (flush) begin
            valid <= '0;
        end else if (write_en) begin
            valid[wr_idx] <= 1'b1;
        end
    end

    // Tag and target are replaced outright on a write
    always_ff @(posedge CLK) begin
        if (write_en) begin
            tags[wr_idx]    <= wr_tag;
            targets[wr_idx] <= write_target;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/branch_decoder.sv ====
`default_nettype none

`include "bp_settings.svh"

module branch_decoder
    import bp_pkg::*;
(
    input  instr_t instr,
    output logic   is_cond,
    output logic   is_jump,
    output logic   is_call,
    output logic   is_return
);

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] FN_JR      = 6'h08;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] rs;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rs     = instr[25:21];

    assign is_cond = (opcode == OP_BEQ) || (opcode == OP_BNE);
    assign is_jump = (opcode == OP_J) || (opcode == OP_JAL);
    assign is_call = (opcode == OP_JAL);

    // Only jr through the link register counts as a return
    assign is_return = (opcode == OP_SPECIAL) && (funct == FN_JR) && (rs == `BP_LINK_REG);

endmodule

`default_nettype wire

// ==== verilog/bp_pkg.sv ====
`default_nettype none

`include "bp_settings.svh"

package bp_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;

    // 2-bit saturating counter, upper half means taken
    typedef logic [1:0] ctr_t;

    typedef logic [`BP_GHR_BITS-1:0] ghist_t;
    typedef logic [`BP_LHR_BITS-1:0] lhist_t;

    // One saturating step toward the given direction
    function automatic ctr_t ctr_step(input ctr_t cur, input logic up);
        ctr_t nxt;
        nxt = cur;
        if (up && cur != 2'd3) begin
            nxt = cur + 2'd1;
        end else if (!up && cur != 2'd0) begin
            nxt = cur - 2'd1;
        end
        return nxt;
    endfunction

endpackage

`default_nettype wire

// ==== verilog/bp_settings.svh ====
`ifndef BP_SETTINGS_SVH
`define BP_SETTINGS_SVH

// Direct-mapped BTB, index from PC[5:2]
`define BP_BTB_ENTRIES 16

// Global history length, sets the gshare and meta table size to 64
`define BP_GHR_BITS 6

// Local history length, 16-entry history and pattern tables
`define BP_LHR_BITS 4

// Return stack depth
`define BP_RAS_DEPTH 4

// Link register used by jal and returned through by jr
`define BP_LINK_REG 5'd31

`endif
